// File: design/list_walk_mem_pkg.sv
// List walker memory definitions
`default_nettype none

package list_walk_mem_pkg;

    // ========================================
    // Memory port widths
    // ========================================

    // Memory addresses count 64-bit words, not bytes
    localparam int MEM_ADDR_W = 32;

    // Every memory transfer moves one 64-bit word
    localparam int MEM_DATA_W = 64;

    // ========================================
    // Node layout
    // ========================================

    // A node is four consecutive words starting at its base address
    localparam int NODE_WORDS = 4;

    // The first word of a node holds the address of the next node
    // A value of zero in that word ends the list
    localparam int NEXT_WORD = 0;

    // Software spins on the flag word until it reads this value
    localparam int RESULT_FLAG = 1;

    // ========================================
    // Types
    // ========================================

    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [MEM_DATA_W-1:0] mem_data_t;

    // Selects one word inside a node
    typedef logic [$clog2(NODE_WORDS)-1:0] node_word_t;

endpackage

`default_nettype wire

// File: design/list_walk_csr_pkg.sv
// List walker CSR map
`default_nettype none

package list_walk_csr_pkg;

    // ========================================
    // CSR address map
    // ========================================

    // CSR offsets are in 64-bit words
    localparam int CSR_ADDR_W = 4;

    // Write only registers
    // The result address must be written before the start address
    localparam logic [CSR_ADDR_W-1:0] CSR_RESULT_ADDR = 4'd5;
    // Writing the start address launches a walk
    localparam logic [CSR_ADDR_W-1:0] CSR_START_ADDR = 4'd6;

    // Read only registers
    // Number of nodes visited by the last walk
    localparam logic [CSR_ADDR_W-1:0] CSR_LIST_LENGTH = 4'd3;
    // Number of data words added into the checksum
    localparam logic [CSR_ADDR_W-1:0] CSR_DATA_ENTRIES = 4'd4;

    // ========================================
    // Types
    // ========================================

    // Counters wrap silently on overflow
    typedef logic [15:0] count_t;

endpackage

`default_nettype wire

// File: design/csr_decode.sv
// CSR slave for the list walker
`timescale 1ns/1ps
`default_nettype none

module csr_decode
    import list_walk_mem_pkg::*;
    import list_walk_csr_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset,

    // Wishbone classic slave
    input  wire logic                  csr_cyc,
    input  wire logic                  csr_stb,
    input  wire logic                  csr_we,
    input  wire logic [CSR_ADDR_W-1:0] csr_adr,
    input  wire mem_data_t             csr_dat_w,
    output      mem_data_t             csr_dat_r,
    output      logic                  csr_ack,

    // Walk control towards the execute stage
    output      logic                  start,
    output      mem_addr_t             start_addr,
    output      mem_addr_t             result_addr,

    // Counts returned on reads
    input  wire count_t                list_length,
    input  wire count_t                data_entries
);

    // A request is taken only while no ack is pending, so a master that
    // holds stb through the ack cycle does not get a second ack
    logic csr_req;

    assign csr_req = csr_cyc && csr_stb && !csr_ack;

    // ========================================
    // Handshake and start pulse
    // ========================================

    // The ack and the start pulse rise together, one cycle after the request
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            csr_ack <= 1'b0;
            start   <= 1'b0;
        end
        else
        begin
            csr_ack <= csr_req;
            start   <= csr_req && csr_we && (csr_adr == CSR_START_ADDR);
        end
    end

    // ========================================
    // Address registers
    // ========================================

    // Only the low bits of the 64-bit write data form a word address
    always_ff @(posedge clk)
    begin
        if (csr_req && csr_we)
        begin
            case (csr_adr)
                CSR_RESULT_ADDR: result_addr <= csr_dat_w[MEM_ADDR_W-1:0];
                CSR_START_ADDR:  start_addr  <= csr_dat_w[MEM_ADDR_W-1:0];
                // Writes to any other offset are dropped
                default: ;
            endcase
        end
    end

    // ========================================
    // Read data
    // ========================================

    // Read data is registered so it lines up with the ack
    // Counts are zero-extended to the full data width
    always_ff @(posedge clk)
    begin
        if (csr_req && !csr_we)
        begin
            case (csr_adr)
                CSR_LIST_LENGTH:  csr_dat_r <= mem_data_t'(list_length);
                CSR_DATA_ENTRIES: csr_dat_r <= mem_data_t'(data_entries);
                default:          csr_dat_r <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/walk_execute.sv
// List walk state machine
`timescale 1ns/1ps
`default_nettype none

module walk_execute
    import list_walk_mem_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,

    // Control from the CSR block
    input  wire logic       start,
    input  wire mem_addr_t  start_addr,
    input  wire mem_addr_t  result_addr,

    // Wishbone classic master towards memory
    output      logic       mem_cyc,
    output      logic       mem_stb,
    output      logic       mem_we,
    output      mem_addr_t  mem_adr,
    output      mem_data_t  mem_dat_w,
    input  wire mem_data_t  mem_dat_r,
    input  wire logic       mem_ack,

    // Events for the checksum block
    output      logic       walk_begin,
    output      logic       node_fetch,
    output      logic       data_valid,
    output      mem_data_t  data_word,
    input  wire mem_data_t  checksum
);

    // Index of the final word of a node
    localparam node_word_t LAST_WORD = node_word_t'(NODE_WORDS - 1);

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_READ,
        ST_WRITE_SUM,
        ST_WRITE_FLAG
    } state_t;

    state_t     state;

    // Single request flag drives both cyc and stb
    logic       req;
    logic       xfer_done;

    // Position within the list
    mem_addr_t  node_base;
    node_word_t word_idx;
    mem_addr_t  next_ptr;

    // Result address is held for the whole walk
    mem_addr_t  result_base;

    assign mem_cyc   = req;
    assign mem_stb   = req;
    assign xfer_done = req && mem_ack;

    // ========================================
    // Events for the checksum block
    // ========================================

    // A start is accepted only while idle, later ones are dropped
    assign walk_begin = start && (state == ST_IDLE);
    assign node_fetch = xfer_done && (state == ST_READ) && (word_idx == node_word_t'(NEXT_WORD));
    assign data_valid = xfer_done && (state == ST_READ) && (word_idx != node_word_t'(NEXT_WORD));
    assign data_word  = mem_dat_r;

    // ========================================
    // Walk sequencing
    // ========================================

    // Every transfer ends with one idle cycle: the ack edge drops req,
    // and the next edge presents the following transfer
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state  <= ST_IDLE;
            req    <= 1'b0;
            mem_we <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    // First read goes out on the cycle after the start pulse
                    if (start)
                    begin
                        req    <= 1'b1;
                        mem_we <= 1'b0;
                        state  <= ST_READ;
                    end
                end

                ST_READ:
                begin
                    if (xfer_done)
                    begin
                        req <= 1'b0;
                        // The end test uses the pointer caught at word 0
                        if (word_idx == LAST_WORD && next_ptr == '0)
                        begin
                            state <= ST_WRITE_SUM;
                        end
                    end
                    else if (!req)
                    begin
                        req <= 1'b1;
                    end
                end

                ST_WRITE_SUM:
                begin
                    if (xfer_done)
                    begin
                        req    <= 1'b0;
                        mem_we <= 1'b0;
                        state  <= ST_WRITE_FLAG;
                    end
                    else if (!req)
                    begin
                        req    <= 1'b1;
                        mem_we <= 1'b1;
                    end
                end

                ST_WRITE_FLAG:
                begin
                    // Flag goes last so software never sees a stale checksum
                    if (xfer_done)
                    begin
                        req    <= 1'b0;
                        mem_we <= 1'b0;
                        state  <= ST_IDLE;
                    end
                    else if (!req)
                    begin
                        req    <= 1'b1;
                        mem_we <= 1'b1;
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

    // ========================================
    // Addresses and write data
    // ========================================

    // The checksum is final by the idle cycle before its write
    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && start)
        begin
            node_base   <= start_addr;
            word_idx    <= '0;
            result_base <= result_addr;
            mem_adr     <= start_addr;
        end
        else if (state == ST_READ && xfer_done)
        begin
            if (word_idx == node_word_t'(NEXT_WORD))
            begin
                next_ptr <= mem_dat_r[MEM_ADDR_W-1:0];
            end
            if (word_idx == LAST_WORD)
            begin
                node_base <= next_ptr;
                word_idx  <= '0;
            end
            else
            begin
                word_idx <= word_idx + 1'b1;
            end
        end
        else if (!req)
        begin
            case (state)
                ST_READ:      mem_adr <= node_base + mem_addr_t'(word_idx);
                ST_WRITE_SUM:
                begin
                    mem_adr   <= result_base + mem_addr_t'(1);
                    mem_dat_w <= checksum;
                end
                ST_WRITE_FLAG:
                begin
                    mem_adr   <= result_base;
                    mem_dat_w <= mem_data_t'(RESULT_FLAG);
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/checksum_result.sv
// Checksum and walk counters
`timescale 1ns/1ps
`default_nettype none

module checksum_result
    import list_walk_mem_pkg::*;
    import list_walk_csr_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,

    // Events from the walk state machine
    input  wire logic      walk_begin,
    input  wire logic      node_fetch,
    input  wire logic      data_valid,
    input  wire mem_data_t data_word,

    // Running results
    output      mem_data_t checksum,
    output      count_t    list_length,
    output      count_t    data_entries
);

    // ========================================
    // Checksum
    // ========================================

    // Plain 64-bit sum of every data word, carries out of the top are lost
    always_ff @(posedge clk)
    begin
        if (reset || walk_begin)
        begin
            checksum <= '0;
        end
        else if (data_valid)
        begin
            checksum <= checksum + data_word;
        end
    end

    // ========================================
    // Counters
    // ========================================

    // One count per node, taken when the next pointer arrives
    always_ff @(posedge clk)
    begin
        if (reset || walk_begin)
        begin
            list_length <= '0;
        end
        else if (node_fetch)
        begin
            list_length <= list_length + 1'b1;
        end
    end

    // One count per data word added into the checksum
    // Both counters hold after the walk so software can read them
    always_ff @(posedge clk)
    begin
        if (reset || walk_begin)
        begin
            data_entries <= '0;
        end
        else if (data_valid)
        begin
            data_entries <= data_entries + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/list_walk_top.sv
// Linked list checksum walker
`timescale 1ns/1ps
`default_nettype none

module list_walk_top
    import list_walk_mem_pkg::*;
    import list_walk_csr_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset,

    // CSR port, Wishbone classic slave
    input  wire logic                  csr_cyc,
    input  wire logic                  csr_stb,
    input  wire logic                  csr_we,
    input  wire logic [CSR_ADDR_W-1:0] csr_adr,
    input  wire mem_data_t             csr_dat_w,
    output      mem_data_t             csr_dat_r,
    output      logic                  csr_ack,

    // Memory port, Wishbone classic master
    output      logic                  mem_cyc,
    output      logic                  mem_stb,
    output      logic                  mem_we,
    output      mem_addr_t             mem_adr,
    output      mem_data_t             mem_dat_w,
    input  wire mem_data_t             mem_dat_r,
    input  wire logic                  mem_ack
);

    // CSR block to walker
    logic      start;
    mem_addr_t start_addr;
    mem_addr_t result_addr;

    // Walker to checksum block
    logic      walk_begin;
    logic      node_fetch;
    logic      data_valid;
    mem_data_t data_word;

    // Checksum block back to the walker and the CSR block
    mem_data_t checksum;
    count_t    list_length;
    count_t    data_entries;

    // ========================================
    // Decode
    // ========================================

    csr_decode u_decode (
        .clk          (clk),
        .reset        (reset),
        .csr_cyc      (csr_cyc),
        .csr_stb      (csr_stb),
        .csr_we       (csr_we),
        .csr_adr      (csr_adr),
        .csr_dat_w    (csr_dat_w),
        .csr_dat_r    (csr_dat_r),
        .csr_ack      (csr_ack),
        .start        (start),
        .start_addr   (start_addr),
        .result_addr  (result_addr),
        .list_length  (list_length),
        .data_entries (data_entries)
    );

    // ========================================
    // Execute
    // ========================================

    walk_execute u_execute (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .start_addr  (start_addr),
        .result_addr (result_addr),
        .mem_cyc     (mem_cyc),
        .mem_stb     (mem_stb),
        .mem_we      (mem_we),
        .mem_adr     (mem_adr),
        .mem_dat_w   (mem_dat_w),
        .mem_dat_r   (mem_dat_r),
        .mem_ack     (mem_ack),
        .walk_begin  (walk_begin),
        .node_fetch  (node_fetch),
        .data_valid  (data_valid),
        .data_word   (data_word),
        .checksum    (checksum)
    );

    // ========================================
    // Result
    // ========================================

    checksum_result u_result (
        .clk          (clk),
        .reset        (reset),
        .walk_begin   (walk_begin),
        .node_fetch   (node_fetch),
        .data_valid   (data_valid),
        .data_word    (data_word),
        .checksum     (checksum),
        .list_length  (list_length),
        .data_entries (data_entries)
    );

endmodule

`default_nettype wire

// File: testbench/list_walk_checker.sv
// List walker result checker
`timescale 1ns/1ps
`default_nettype none

module list_walk_checker
    import list_walk_mem_pkg::*;
    import list_walk_csr_pkg::*;
#(
    parameter int MEM_WORDS = 4096
)
(
    input  wire logic                  clk,
    input  wire logic                  reset,

    // CSR port as seen on the DUT pins
    input  wire logic                  csr_cyc,
    input  wire logic                  csr_stb,
    input  wire logic                  csr_we,
    input  wire logic [CSR_ADDR_W-1:0] csr_adr,
    input  wire mem_data_t             csr_dat_r,
    input  wire logic                  csr_ack,

    // Memory port as seen on the DUT pins
    input  wire logic                  mem_cyc,
    input  wire logic                  mem_stb,
    input  wire logic                  mem_we,
    input  wire mem_addr_t             mem_adr,
    input  wire mem_data_t             mem_dat_w,
    input  wire logic                  mem_ack
);

    // Copy of the node words as the testbench stored them
    mem_data_t             image [MEM_WORDS];

    // Expected results of the current test
    string                 test_name;
    mem_addr_t             exp_result;
    mem_data_t             exp_sum;
    mem_data_t             exp_nodes;
    mem_data_t             exp_words;
    int                    exp_writes;

    // Progress of the current test
    int                    write_count;
    int                    test_errors;
    int                    pass_count;
    int                    fail_count;
    bit                    active;
    bit                    walk_done;
    bit                    read_pending;
    logic [CSR_ADDR_W-1:0] read_adr;

    // ========================================
    // Reference model
    // ========================================

    // Follows the next pointers through the copy and adds every data word
    // The node limit stops a corrupt list from looping forever
    function automatic void walk_reference(input mem_addr_t head, output mem_data_t sum,
                                           output mem_data_t nodes, output mem_data_t words);
        mem_addr_t node;
        int        w;
        sum   = '0;
        nodes = '0;
        words = '0;
        node  = head;
        do
        begin
            nodes = nodes + 1;
            for (w = 1; w < NODE_WORDS; w++)
            begin
                sum   = sum + image[node + mem_addr_t'(w)];
                words = words + 1;
            end
            node = image[node][MEM_ADDR_W-1:0];
        end
        while (node != '0 && nodes < MEM_WORDS);
    endfunction

    // ========================================
    // Reporting
    // ========================================

    task automatic value_error(input string what, input mem_data_t expected,
                               input mem_data_t actual);
        test_errors++;
        $display("ERR %s %s expected %h actual %h", test_name, what, expected, actual);
    endtask

    task automatic report_problem(input string msg);
        test_errors++;
        $display("%s: %s", test_name, msg);
    endtask

    // Called before the CSR writes that launch a walk
    task automatic begin_test(input string name, input mem_addr_t head, input mem_addr_t result);
        test_name   = name;
        exp_result  = result;
        exp_writes  = 2;
        write_count = 0;
        test_errors = 0;
        walk_done   = 1'b0;
        active      = 1'b1;
        walk_reference(head, exp_sum, exp_nodes, exp_words);
    endtask

    // A CSR only test keeps the counts expected from the last walk
    task automatic begin_readback(input string name);
        test_name   = name;
        exp_writes  = 0;
        write_count = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (write_count != exp_writes)
            report_problem($sformatf("saw %0d result writes, %0d were due",
                                     write_count, exp_writes));
        if (test_errors == 0)
        begin
            pass_count++;
            $display("ok   %s", test_name);
        end
        else
        begin
            fail_count++;
            $display("fail %s with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic print_counts();
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
    endtask

    // ========================================
    // Memory writes
    // ========================================

    // The checksum must land before the flag, software polls the flag
    task automatic check_write();
        write_count++;
        if (write_count == 1)
        begin
            if (mem_adr === exp_result)
                report_problem("flag written before the checksum");
            else if (mem_adr !== exp_result + 1)
                value_error("checksum address", exp_result + 1, mem_adr);
            else if (mem_dat_w !== exp_sum)
                value_error("checksum", exp_sum, mem_dat_w);
        end
        else
        begin
            if (mem_adr !== exp_result)
                value_error("flag address", exp_result, mem_adr);
            else if (mem_dat_w !== mem_data_t'(RESULT_FLAG))
                value_error("flag", mem_data_t'(RESULT_FLAG), mem_dat_w);
            active    = 1'b0;
            walk_done = 1'b1;
        end
    endtask

    // Every acked transfer is looked at, reads only matter outside a walk
    always @(posedge clk)
    begin
        if (!reset && mem_cyc && mem_stb && mem_ack)
        begin
            if (!active)
                report_problem("memory transfer while no walk was running");
            else if (mem_we)
                check_write();
        end
    end

    // ========================================
    // CSR reads
    // ========================================

    task automatic check_read();
        mem_data_t expected;
        case (read_adr)
            CSR_LIST_LENGTH:  expected = exp_nodes;
            CSR_DATA_ENTRIES: expected = exp_words;
            default:          expected = '0;
        endcase
        if (csr_dat_r !== expected)
            value_error($sformatf("CSR offset %0d", read_adr), expected, csr_dat_r);
    endtask

    // The offset is caught with the request, the data with the ack
    always @(posedge clk)
    begin
        if (reset)
            read_pending = 1'b0;
        else
        begin
            if (csr_ack && read_pending)
            begin
                check_read();
                read_pending = 1'b0;
            end
            if (csr_cyc && csr_stb && !csr_ack)
            begin
                read_pending = !csr_we;
                read_adr     = csr_adr;
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_list_walk.sv
// List walker testbench
`timescale 1ns/1ps
`default_nettype none

module tb_list_walk
    import list_walk_mem_pkg::*;
    import list_walk_csr_pkg::*;
();

    localparam int MEM_WORDS  = 4096;
    // Lists live in node slots 1 to 1000 and the results sit above them
    localparam int LIST_SLOTS = 1000;
    localparam mem_addr_t RESULT_A = 32'd4064;
    localparam mem_addr_t RESULT_B = 32'd4080;
    // Nodes walked over all tests
    // The list whose start is ignored is never walked
    localparam int TOTAL_NODES     = 1 + 12 + 8 + 5;
    localparam int WATCHDOG_CYCLES = TOTAL_NODES * NODE_WORDS * 6 + 2000;

    logic                  clk;
    logic                  reset;
    logic                  csr_cyc;
    logic                  csr_stb;
    logic                  csr_we;
    logic [CSR_ADDR_W-1:0] csr_adr;
    mem_data_t             csr_dat_w;
    mem_data_t             csr_dat_r;
    logic                  csr_ack;
    logic                  mem_cyc;
    logic                  mem_stb;
    logic                  mem_we;
    mem_addr_t             mem_adr;
    mem_data_t             mem_dat_w;
    mem_data_t             mem_dat_r;
    logic                  mem_ack;

    // Memory model state
    mem_data_t             mem [MEM_WORDS];
    bit                    slot_used [LIST_SLOTS + 1];
    logic [63:0]           rng_state = 64'd76918;
    logic                  pending;
    int unsigned           waits;
    mem_addr_t             head;
    mem_addr_t             other;

    list_walk_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .csr_cyc   (csr_cyc),
        .csr_stb   (csr_stb),
        .csr_we    (csr_we),
        .csr_adr   (csr_adr),
        .csr_dat_w (csr_dat_w),
        .csr_dat_r (csr_dat_r),
        .csr_ack   (csr_ack),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_we    (mem_we),
        .mem_adr   (mem_adr),
        .mem_dat_w (mem_dat_w),
        .mem_dat_r (mem_dat_r),
        .mem_ack   (mem_ack)
    );

    list_walk_checker #(.MEM_WORDS(MEM_WORDS)) u_check (
        .clk       (clk),
        .reset     (reset),
        .csr_cyc   (csr_cyc),
        .csr_stb   (csr_stb),
        .csr_we    (csr_we),
        .csr_adr   (csr_adr),
        .csr_dat_r (csr_dat_r),
        .csr_ack   (csr_ack),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_we    (mem_we),
        .mem_adr   (mem_adr),
        .mem_dat_w (mem_dat_w),
        .mem_ack   (mem_ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ========================================
    // Stimulus helpers
    // ========================================

    // A 64-bit LCG whose upper half has the best randomness
    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return rng_state[63:32];
    endfunction

    // The memory model and the reference copy always hold the same node words
    task automatic store_word(input mem_addr_t addr, input mem_data_t data);
        mem[addr]           = data;
        u_check.image[addr] = data;
    endtask

    // Builds the list back to front, so the last node made is the head
    task automatic build_list(input int nodes, output mem_addr_t first);
        mem_addr_t next;
        mem_addr_t base;
        mem_data_t data;
        int        slot;
        int        n;
        int        w;
        next = '0;
        for (n = 0; n < nodes; n++)
        begin
            // Pick a scattered free slot
            // Slot 0 is never used so no node sits at address 0
            slot = 1 + int'(lcg_next() % LIST_SLOTS);
            while (slot_used[slot])
                slot = 1 + int'(lcg_next() % LIST_SLOTS);
            slot_used[slot] = 1'b1;
            base = mem_addr_t'(slot * NODE_WORDS);
            store_word(base, mem_data_t'(next));
            for (w = 1; w < NODE_WORDS; w++)
            begin
                data[63:32] = lcg_next();
                data[31:0]  = lcg_next();
                store_word(base + mem_addr_t'(w), data);
            end
            next = base;
        end
        first = next;
    endtask

    // One Wishbone classic access driven 1 ns after the edge
    task automatic csr_access(input logic write, input logic [CSR_ADDR_W-1:0] adr,
                              input mem_data_t data);
        @(posedge clk);
        #1;
        csr_cyc   = 1'b1;
        csr_stb   = 1'b1;
        csr_we    = write;
        csr_adr   = adr;
        csr_dat_w = data;
        do
        begin
            @(posedge clk);
            #1;
        end
        while (!csr_ack);
        csr_cyc = 1'b0;
        csr_stb = 1'b0;
        csr_we  = 1'b0;
        // Let the ack cycle close so the checker sees the read data
        @(posedge clk);
        #1;
    endtask

    task automatic launch_walk(input string name, input mem_addr_t first, input mem_addr_t result);
        u_check.begin_test(name, first, result);
        csr_access(1'b1, CSR_RESULT_ADDR, mem_data_t'(result));
        csr_access(1'b1, CSR_START_ADDR, mem_data_t'(first));
    endtask

    // The checker raises walk_done on the flag write
    task automatic wait_walk();
        while (!u_check.walk_done)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // ========================================
    // Memory model
    // ========================================

    // Wishbone slave with 0 to 3 wait cycles before each ack
    initial
    begin
        forever
        begin
            @(posedge clk);
            #1;
            if (reset || mem_ack)
            begin
                mem_ack = 1'b0;
                pending = 1'b0;
            end
            else if (mem_cyc && mem_stb)
            begin
                if (!pending)
                begin
                    pending = 1'b1;
                    waits   = lcg_next() % 4;
                end
                if (waits == 0)
                begin
                    pending = 1'b0;
                    mem_ack = 1'b1;
                    if (mem_we)
                        mem[mem_adr] = mem_dat_w;
                    else
                        mem_dat_r = mem[mem_adr];
                end
                else
                    waits--;
            end
        end
    end

    // ========================================
    // Test sequence
    // ========================================

    initial
    begin
        reset     = 1'b1;
        csr_cyc   = 1'b0;
        csr_stb   = 1'b0;
        csr_we    = 1'b0;
        csr_adr   = '0;
        csr_dat_w = '0;
        mem_dat_r = '0;
        mem_ack   = 1'b0;
        pending   = 1'b0;
        waits     = 0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        build_list(1, head);
        launch_walk("single_node", head, RESULT_A);
        wait_walk();
        u_check.end_test();

        build_list(12, head);
        launch_walk("random_12_nodes", head, RESULT_A);
        wait_walk();
        u_check.end_test();

        // Read the counts of the twelve node walk and then an offset with no register
        u_check.begin_readback("csr_counts");
        csr_access(1'b0, CSR_LIST_LENGTH, '0);
        csr_access(1'b0, CSR_DATA_ENTRIES, '0);
        csr_access(1'b0, 4'd9, '0);
        u_check.end_test();

        // The second start arrives while the first list is still being read
        build_list(8, head);
        build_list(3, other);
        launch_walk("start_while_busy", head, RESULT_A);
        csr_access(1'b1, CSR_START_ADDR, mem_data_t'(other));
        wait_walk();
        repeat (50) @(posedge clk);
        #1;
        u_check.end_test();

        build_list(5, head);
        launch_walk("second_walk", head, RESULT_B);
        wait_walk();
        csr_access(1'b0, CSR_LIST_LENGTH, '0);
        csr_access(1'b0, CSR_DATA_ENTRIES, '0);
        u_check.end_test();

        u_check.print_counts();
        if (u_check.fail_count == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // Watchdog sized from the node count of all walks
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, a walk never finished", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: list_walk.f
design/list_walk_mem_pkg.sv
design/list_walk_csr_pkg.sv
design/csr_decode.sv
design/walk_execute.sv
design/checksum_result.sv
design/list_walk_top.sv
testbench/list_walk_checker.sv
testbench/tb_list_walk.sv
